// ==== i2cController.f ====
src/i2cBusPkg.sv
src/i2cHostPkg.sv
src/i2cClockDivider.sv
src/i2cQueue.sv
src/i2cBitEngine.sv
src/i2cRegisterBank.sv
src/i2cController.sv
testbench/i2cClockGen.sv
testbench/i2cSlaveModel.sv
testbench/i2cChecker.sv
testbench/i2cTestbench.sv

// ==== testbench/i2cTestbench.sv ====
// top of the i2c master testbench
// test table, host register tasks, run loop, random read table, watchdog
// clock/reset generator, DUT with pulled-up bus, slave model, checker
`timescale 1ns/100ps
`default_nettype none

module i2cTestbench;
    import i2cBusPkg::*;
    import i2cHostPkg::*;

    localparam int periodNs = 20;
    localparam int rowCount = 6;
    localparam int kindIdle  = 0;       // status and lines only
    localparam int kindWrite = 1;
    localparam int kindRead  = 2;
    localparam int kindRaw   = 3;       // data writes with no start, back to back

    logic       clk, reset;
    logic [1:0] regAddr;
    logic       regWrite, regRead;
    logic [7:0] regWriteData;
    logic [7:0] regReadData;
    logic       rowActive;
    wire        scl, sda;

    // test table
    string       rowName   [rowCount];
    int          rowKind   [rowCount];
    int          rowCycles [rowCount];  // clocksPerCycle for the test
    logic [6:0]  rowAddr   [rowCount];
    int          rowBytes  [rowCount];
    logic [39:0] rowData   [rowCount];  // up to five bytes, first in the top byte
    logic        rowNack   [rowCount];
    logic [7:0]  readTable [8];
    int          readNext = 0;
    int          seedDraw;
    int          limitNs;

    pullup (scl);
    pullup (sda);

    i2cClockGen #(.periodNs(periodNs), .resetCycles(4)) clockGen (.clk, .reset);

    i2cController i2cController_inst (
        .clk, .reset, .regAddr, .regWrite, .regRead, .regWriteData, .regReadData,
        .scl, .sda
    );

    i2cSlaveModel #(.slaveAddress(7'h42)) slaveModel (.scl, .sda);

    i2cChecker resultChecker (
        .clk, .regAddr, .regRead, .regReadData, .scl, .rowActive
    );

    task automatic setRow(input int r, input string name, input int kind, input int cycles,
                          input logic [6:0] addr, input int count, input logic [39:0] data,
                          input logic nack);
        rowName[r]   = name;
        rowKind[r]   = kind;
        rowCycles[r] = cycles;
        rowAddr[r]   = addr;
        rowBytes[r]  = count;
        rowData[r]   = data;
        rowNack[r]   = nack;
    endtask

    // host tasks start and end on a falling edge
    task automatic writeReg(input logic [1:0] addr, input logic [7:0] value);
        regAddr      = addr;
        regWriteData = value;
        regWrite     = 1'b1;
        @(negedge clk);
        regWrite     = 1'b0;
    endtask

    task automatic readReg(input logic [1:0] addr, output logic [7:0] value);
        regAddr = addr;
        regRead = 1'b1;
        @(negedge clk);
        regRead = 1'b0;
        value   = regReadData;          // registered one clock after regRead
    endtask

    task automatic pushWrite(input logic [1:0] addr, input logic [7:0] value);
        logic [7:0] status;
        readReg(regStatus, status);
        while (status[statusCmdFull]) readReg(regStatus, status);
        writeReg(addr, value);
    endtask

    task automatic waitIdle();
        logic [7:0] status;
        readReg(regStatus, status);
        while (status[statusBusy]) readReg(regStatus, status);
    endtask

    task automatic runRow(input int r);
        logic [7:0] status;
        logic [7:0] addrByte;
        logic [7:0] expected [$];
        int         accepted;
        resultChecker.startRow(rowName[r], 2 * (rowCycles[r] + 1)); // scl high = two phases
        rowActive = 1'b1;
        slaveModel.seenBytes.delete();
        slaveModel.ackLog.delete();
        if (rowKind[r] == kindIdle) begin
            readReg(regStatus, status);
            resultChecker.checkValue("status register", 0, status);
            resultChecker.checkValue("scl level", 1, scl);
            resultChecker.checkValue("sda level", 1, sda);
        end else begin
            writeReg(regConfig, 8'(rowCycles[r]));
            if (rowKind[r] == kindRaw) begin
                // engine waits a full phase after the config write, so the queue fills
                accepted = (rowBytes[r] < queueDepth) ? rowBytes[r] : queueDepth;
                for (int j = 0; j < rowBytes[r]; j++) begin
                    if (j == queueDepth) begin
                        readReg(regStatus, status);
                        resultChecker.checkValue("command full flag", 1, status[statusCmdFull]);
                    end
                    writeReg(regData, rowData[r][39 - 8 * j -: 8]);
                end
                for (int j = 0; j < accepted; j++) expected.push_back(rowData[r][39 - 8 * j -: 8]);
            end else begin
                addrByte = {rowAddr[r], rowKind[r] == kindRead};
                pushWrite(regCommand, {6'd0, START});
                pushWrite(regData, addrByte);
                expected.push_back(addrByte);
                for (int j = 0; j < rowBytes[r]; j++) begin
                    if (rowKind[r] == kindWrite) begin
                        pushWrite(regData, rowData[r][39 - 8 * j -: 8]);
                        expected.push_back(rowData[r][39 - 8 * j -: 8]);
                    end else begin
                        pushWrite(regCommand, {5'd0, j == rowBytes[r] - 1, RECEIVE}); // nack last
                    end
                end
                pushWrite(regCommand, {6'd0, STOP});
            end
            waitIdle();
            if (rowKind[r] == kindRead) begin
                for (int j = 0; j < rowBytes[r]; j++) begin
                    resultChecker.expectRead(readTable[readNext]);
                    readNext = readNext + 1;
                    readReg(regData, status);
                end
            end
            readReg(regStatus, status);
            resultChecker.checkValue("nack flag", rowNack[r], status[statusNack]);
            if (status[statusNack]) begin
                writeReg(regStatus, 8'(1 << statusNack));   // write one to clear
                readReg(regStatus, status);
                resultChecker.checkValue("nack after clear", 0, status[statusNack]);
            end
            foreach (expected[j]) begin
                if (j >= slaveModel.seenBytes.size())
                    resultChecker.reportProblem($sformatf("bus byte %0d never seen", j));
                else
                    resultChecker.checkValue("bus byte", expected[j], slaveModel.seenBytes[j]);
            end
            if (slaveModel.seenBytes.size() > expected.size())
                resultChecker.reportProblem("more bytes on the bus than were queued");
            if (rowKind[r] == kindRead) begin
                for (int j = 0; j < rowBytes[r]; j++) begin
                    if (j >= slaveModel.ackLog.size())
                        resultChecker.reportProblem("master ack slot missing");
                    else
                        resultChecker.checkValue("master ack", j == rowBytes[r] - 1,
                                                 slaveModel.ackLog[j]);
                end
            end
        end
        rowActive = 1'b0;
        resultChecker.endRow();
        @(negedge clk);                 // one clock between tests clears pulse timing
    endtask

    initial begin
        regAddr      = 2'd0;
        regWrite     = 1'b0;
        regRead      = 1'b0;
        regWriteData = 8'd0;
        rowActive    = 1'b0;
        seedDraw     = $urandom(63596);

        setRow(0, "idleAfterReset", kindIdle,  4, 7'h00, 0, 40'h0, 1'b0);
        setRow(1, "writeOneByte",   kindWrite, 4, 7'h42, 1, 40'hA5_00_00_00_00, 1'b0);
        setRow(2, "nackWrongAddr",  kindWrite, 4, 7'h17, 1, 40'h3C_00_00_00_00, 1'b1);
        setRow(3, "readThree",      kindRead,  4, 7'h42, 3, 40'h0, 1'b0);
        setRow(4, "slowClockWrite", kindWrite, 9, 7'h42, 1, 40'h5A_00_00_00_00, 1'b0);
        setRow(5, "queueFullRaw",   kindRaw,   9, 7'h00, 5, 40'h11_22_33_44_55, 1'b1);

        foreach (readTable[i]) begin
            readTable[i] = 8'($urandom);
            slaveModel.readTable[i] = readTable[i];
        end

        // bytes x 36 phases x phase clocks x period, doubled
        limitNs = 0;
        for (int r = 0; r < rowCount; r++) begin
            limitNs = limitNs + (rowBytes[r] + ((rowKind[r] == kindWrite ||
                      rowKind[r] == kindRead) ? 1 : 0)) * 36 * (rowCycles[r] + 1) * periodNs;
        end
        limitNs = 2 * limitNs;
        fork
            begin
                #(limitNs);
                $display("watchdog expired after %0d ns, a test never finished", limitNs);
                $display("TEST FAIL");
                $finish;
            end
        join_none

        @(negedge reset);
        @(negedge clk);
        for (int r = 0; r < rowCount; r++) runRow(r);
        resultChecker.summary();
        if (resultChecker.failCount == 0 && resultChecker.passCount == rowCount) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/i2cChecker.sv ====
// result checker for the i2c testbench
// compares host data reads against queued expectations as they happen
// times every scl high pulse of a test against the phase rule
// value compares, per-test result lines and the closing counts
`timescale 1ns/100ps
`default_nettype none

module i2cChecker (
    input wire       clk,
    input wire [1:0] regAddr,
    input wire       regRead,
    input wire [7:0] regReadData,
    input wire       scl,
    input wire       rowActive          // high while a test runs
);
    import i2cHostPkg::*;

    string      rowName     = "";
    int         rowErrors   = 0;
    int         passCount   = 0;
    int         failCount   = 0;
    int         expectHigh  = 0;        // scl high time in clocks
    int         highClocks  = 0;
    logic [7:0] readExpect [$];
    logic       readPending = 1'b0;
    logic       sclWasHigh  = 1'b1;
    logic       pulseTimed  = 1'b0;     // rise seen inside the current test

    task automatic checkValue(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s %s expected 0x%0h actual 0x%0h",
                     rowName, what, expected, actual);
            rowErrors = rowErrors + 1;
        end
    endtask

    task automatic reportProblem(input string text);
        $display("%s went wrong: %s", rowName, text);
        rowErrors = rowErrors + 1;
    endtask

    task automatic startRow(input string name, input int sclHighClocks);
        rowName    = name;
        rowErrors  = 0;
        expectHigh = sclHighClocks;
        readExpect.delete();
    endtask

    task automatic expectRead(input logic [7:0] value);
        readExpect.push_back(value);
    endtask

    task automatic endRow();
        if (readExpect.size() != 0) reportProblem("an expected data read never happened");
        if (rowErrors == 0) begin
            $display("ok      %s", rowName);
            passCount = passCount + 1;
        end else begin
            $display("FAILED  %s with %0d errors", rowName, rowErrors);
            failCount = failCount + 1;
        end
    endtask

    task automatic summary();
        $display("tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
    endtask

    always @(posedge clk) begin
        // regReadData was loaded at the previous edge
        if (readPending) begin
            if (readExpect.size() == 0) reportProblem("data register read with nothing expected");
            else checkValue("read data", readExpect.pop_front(), regReadData);
        end
        readPending = regRead && (regAddr == regData);

        if (!rowActive) pulseTimed = 1'b0;
        if (scl === 1'b1) begin
            if (!sclWasHigh) pulseTimed = rowActive;
            highClocks = highClocks + 1;
        end else begin
            if (sclWasHigh && pulseTimed) checkValue("scl high clocks", expectHigh, highClocks);
            highClocks = 0;
        end
        sclWasHigh = (scl === 1'b1);
    end

endmodule

`default_nettype wire

// ==== testbench/i2cSlaveModel.sv ====
// behavioral i2c slave with a fixed 7-bit address
// logs every byte the master clocks onto the bus, acks its own address and writes
// returns bytes from readTable on reads and logs the master ack level per byte
`timescale 1ns/100ps
`default_nettype none

module i2cSlaveModel #(
    parameter logic [6:0] slaveAddress = 7'h42
) (
    inout wire scl,
    inout wire sda
);

    logic [7:0] readTable [8];          // filled by the testbench before any read
    logic [7:0] seenBytes [$];          // master-driven bytes, address included
    logic       ackLog [$];             // 1 = master nacked our byte
    int         bitCount  = 0;
    int         readIndex = 0;
    logic [7:0] shiftReg  = 8'd0;
    logic [7:0] txByte    = 8'd0;
    logic       firstByte = 1'b0;       // next byte is an address
    logic       addressed = 1'b0;
    logic       readMode  = 1'b0;
    logic       sending   = 1'b0;       // slave owns the data bits
    logic       sdaDrive  = 1'b1;

    assign sda = sdaDrive ? 1'bz : 1'b0;

    task automatic loadNext();
        txByte    = readTable[readIndex];
        readIndex = readIndex + 1;
    endtask

    always @(negedge sda) begin
        if (scl === 1'b1) begin         // start condition
            bitCount  = 0;
            firstByte = 1'b1;
            addressed = 1'b0;
            readMode  = 1'b0;
            sending   = 1'b0;
            sdaDrive  = 1'b1;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin         // stop condition, bus free
            bitCount  = 0;
            firstByte = 1'b0;
            addressed = 1'b0;
            sending   = 1'b0;
            sdaDrive  = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (bitCount < 8) begin
            shiftReg = {shiftReg[6:0], sda};    // msb first
            bitCount = bitCount + 1;
            if (bitCount == 8 && !sending) begin
                seenBytes.push_back(shiftReg);
                if (firstByte) begin
                    addressed = (shiftReg[7:1] == slaveAddress);
                    readMode  = shiftReg[0];
                    firstByte = 1'b0;
                end
            end
        end else begin
            bitCount = 0;               // ninth clock, ack slot
            if (sending) begin
                ackLog.push_back(sda);
                if (sda) begin
                    sending   = 1'b0;   // master done reading
                    addressed = 1'b0;
                end else begin
                    loadNext();
                end
            end else if (addressed && readMode) begin
                sending = 1'b1;         // address acked, start returning data
                loadNext();
            end
        end
    end

    // all slave sda changes happen while scl is low
    always @(negedge scl) begin
        if (bitCount == 8) begin
            sdaDrive = sending || !addressed;   // ack when the byte was ours
        end else if (sending) begin
            sdaDrive = txByte[7 - bitCount];
        end else begin
            sdaDrive = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/i2cClockGen.sv ====
// testbench clock and power-on reset
// free-running clock, reset held for a fixed number of rising edges
`timescale 1ns/100ps
`default_nettype none

module i2cClockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;                   // async, takes effect at time 0
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/i2cController.sv ====
// i2c master controller top
// register bank, command and read queues, phase divider, bit engine
`timescale 1ns/100ps
`default_nettype none

module i2cController (
    input  wire        clk,
    input  wire        reset,
    input  wire  [1:0] regAddr,
    input  wire        regWrite,
    input  wire        regRead,
    input  wire  [7:0] regWriteData,
    output logic [7:0] regReadData,
    inout  wire        scl,
    inout  wire        sda
);
    import i2cBusPkg::*;

    logic           cmdPush, cmdPop, cmdNotEmpty, cmdNotFull;
    i2cCommandEntry cmdEntry, cmdHead;
    logic           readPush, readPop, readNotEmpty, readNotFull;
    i2cReadEntry    readHead;
    logic [7:0]     readByte;           // engine byte into the read queue
    logic [7:0]     clocksPerCycle;
    logic           dividerRestart, cycleDone;
    logic           ackDone, ackSeen, engineIdle;

    i2cRegisterBank registerBank (
        .clk, .reset, .regAddr, .regWrite, .regRead, .regWriteData, .regReadData,
        .cmdPush, .cmdEntry, .cmdNotFull,
        .readPop, .readEntry(readHead), .readNotEmpty,
        .ackDone, .ackSeen, .engineIdle, .cmdNotEmpty,
        .clocksPerCycle, .dividerRestart
    );

    i2cQueue #(.payloadType(i2cCommandEntry)) commandQueue (
        .clk, .reset, .push(cmdPush), .pushData(cmdEntry), .pop(cmdPop),
        .popData(cmdHead), .notEmpty(cmdNotEmpty), .notFull(cmdNotFull)
    );

    i2cQueue #(.payloadType(i2cReadEntry)) readQueue (
        .clk, .reset, .push(readPush), .pushData(readByte), .pop(readPop),
        .popData(readHead), .notEmpty(readNotEmpty), .notFull(readNotFull)
    );

    i2cClockDivider clockDivider (
        .clk, .reset, .clocksPerCycle, .restart(dividerRestart), .cycleDone
    );

    i2cBitEngine bitEngine (
        .clk, .reset, .cycleDone,
        .commandValid(cmdNotEmpty), .commandEntry(cmdHead), .readRoom(readNotFull),
        .commandTaken(cmdPop), .readDone(readPush), .readByte,
        .ackDone, .ackSeen, .engineIdle, .scl, .sda
    );

endmodule

`default_nettype wire

// ==== src/i2cRegisterBank.sv ====
// host register bank for the i2c master
// decodes writes into command queue pushes, reads of data into read queue pops
// config register, sticky NACK flag, status assembly, registered read data
`timescale 1ns/100ps
`default_nettype none

module i2cRegisterBank (
    input  wire        clk,
    input  wire        reset,
    input  wire  [1:0] regAddr,
    input  wire        regWrite,
    input  wire        regRead,
    input  wire  [7:0] regWriteData,
    output logic [7:0] regReadData,
    output logic       cmdPush,
    output i2cBusPkg::i2cCommandEntry cmdEntry,
    input  wire        cmdNotFull,
    output logic       readPop,
    input  wire i2cBusPkg::i2cReadEntry readEntry,
    input  wire        readNotEmpty,
    input  wire        ackDone,
    input  wire        ackSeen,
    input  wire        engineIdle,
    input  wire        cmdNotEmpty,
    output logic [7:0] clocksPerCycle,
    output logic       dividerRestart
);
    import i2cBusPkg::*;
    import i2cHostPkg::*;

    logic       nack;
    logic [7:0] statusValue;
    i2cCommand  writtenCommand;

    assign writtenCommand = i2cCommand'(regWriteData[1:0]);

    // command queue pushes, dropped when full
    always_comb begin
        cmdPush  = 1'b0;
        cmdEntry = '{command: TRANSMIT, data: regWriteData, ack: 1'b0};
        if (regWrite && cmdNotFull) begin
            if (regAddr == regData) begin
                cmdPush = 1'b1;             // byte goes out as a transmit
            end else if (regAddr == regCommand && writtenCommand != TRANSMIT) begin
                cmdPush  = 1'b1;
                cmdEntry = '{command: writtenCommand, data: 8'd0, ack: regWriteData[2]};
            end
        end
    end

    assign readPop = regRead && (regAddr == regData) && readNotEmpty;

    always_comb begin
        statusValue                  = 8'd0;
        statusValue[statusBusy]      = !engineIdle || cmdNotEmpty;
        statusValue[statusNack]      = nack;
        statusValue[statusCmdFull]   = !cmdNotFull;
        statusValue[statusReadAvail] = readNotEmpty;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clocksPerCycle <= dividerReset;
            dividerRestart <= 1'b0;
            nack           <= 1'b0;
            regReadData    <= 8'd0;
        end else begin
            dividerRestart <= regWrite && (regAddr == regConfig); // reload after update
            if (regWrite && regAddr == regConfig) clocksPerCycle <= regWriteData;
            if (ackDone && ackSeen) begin
                nack <= 1'b1;               // a new nack beats a clear
            end else if (regWrite && regAddr == regStatus && regWriteData[statusNack]) begin
                nack <= 1'b0;
            end
            if (regRead) begin
                case (regAddr)
                    regData:   regReadData <= readNotEmpty ? readEntry.data : 8'd0;
                    regConfig: regReadData <= clocksPerCycle;
                    regStatus: regReadData <= statusValue;
                    default:   regReadData <= 8'd0;   // command reg is write only
                endcase
            end
        end
    end

    // a pushed command shows up as busy work on the next clock
    assert property (@(posedge clk) disable iff (reset) cmdPush |=> cmdNotEmpty)
        else $error("command push not accepted by queue");

endmodule

`default_nettype wire

// ==== src/i2cBitEngine.sv ====
// i2c bit engine, phase state machine for start, stop, transmit and receive
// one phase per cycleDone, a state's line action happens on entering it
// open-drain scl/sda from registers, line inputs through one register stage
// leaving start/tx/rx holds scl low so the master keeps the bus between bytes
`timescale 1ns/100ps
`default_nettype none

module i2cBitEngine (
    input  wire        clk,
    input  wire        reset,
    input  wire        cycleDone,
    input  wire        commandValid,
    input  wire i2cBusPkg::i2cCommandEntry commandEntry,
    input  wire        readRoom,        // read queue can take a byte
    output logic       commandTaken,
    output logic       readDone,
    output logic [7:0] readByte,
    output logic       ackDone,
    output logic       ackSeen,         // high = slave did not ack
    output logic       engineIdle,
    inout  wire        scl,
    inout  wire        sda
);
    import i2cBusPkg::*;

    engineState state, nextState;
    logic [2:0] bitCounter, bitCounterNext;
    logic [7:0] dataReg, dataRegNext;   // tx shift out / rx shift in
    logic       ackReg, ackRegNext;     // ack captured on tx, ack to send on rx
    logic       sclOut, sclOutNext;
    logic       sdaOut, sdaOutNext;
    logic       sclIn, sdaIn;
    logic       bitsDone;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            bitCounter <= 3'd0;
            sclOut     <= 1'b1;         // lines released
            sdaOut     <= 1'b1;
            sclIn      <= 1'b1;
            sdaIn      <= 1'b1;
        end else begin
            state      <= nextState;
            bitCounter <= bitCounterNext;
            sclOut     <= sclOutNext;
            sdaOut     <= sdaOutNext;
            sclIn      <= scl;          // sampled only, no stretching support
            sdaIn      <= sda;
        end
    end

    always_ff @(posedge clk) begin
        dataReg <= dataRegNext;
        ackReg  <= ackRegNext;
    end

    assign scl        = sclOut ? 1'bz : 1'b0; // high-z for high, pull down for low
    assign sda        = sdaOut ? 1'bz : 1'b0;
    assign bitsDone   = (bitCounter == 3'd7);
    assign readByte   = dataReg;
    assign ackSeen    = ackReg;
    assign engineIdle = (state == IDLE);

    always_comb begin
        nextState      = state;
        bitCounterNext = bitCounter;
        dataRegNext    = dataReg;
        ackRegNext     = ackReg;
        sclOutNext     = sclOut;
        sdaOutNext     = sdaOut;
        commandTaken   = 1'b0;
        readDone       = 1'b0;
        ackDone        = 1'b0;

        if (cycleDone) begin
            case (state)
                IDLE: begin
                    bitCounterNext = 3'd0;
                    // a receive waits here until the read queue has room
                    if (commandValid && (commandEntry.command != RECEIVE || readRoom)) begin
                        commandTaken = 1'b1;
                        sclOutNext   = 1'b0;    // every sequence opens with scl low
                        case (commandEntry.command)
                            START:    nextState = START1;
                            STOP:     nextState = STOP1;
                            TRANSMIT: begin
                                nextState   = TX1;
                                dataRegNext = commandEntry.data;
                            end
                            RECEIVE:  begin
                                nextState  = RX1;
                                sdaOutNext = 1'b1;  // let the slave drive
                                ackRegNext = commandEntry.ack;
                            end
                        endcase
                    end
                end

                START1: begin nextState = START2; sdaOutNext = 1'b1; end
                START2: begin nextState = START3; sclOutNext = 1'b1; end
                START3: begin nextState = START4; sdaOutNext = 1'b0; end // start condition
                START4: begin nextState = IDLE;   sclOutNext = 1'b0; end

                STOP1:  begin nextState = STOP2;  sdaOutNext = 1'b0; end
                STOP2:  begin nextState = STOP3;  sclOutNext = 1'b1; end
                STOP3:  begin nextState = STOP4;  sdaOutNext = 1'b1; end // stop condition
                STOP4:  nextState = IDLE;       // bus left free, scl high

                TX1: begin                      // msb onto sda while scl low
                    nextState   = TX2;
                    sdaOutNext  = dataReg[7];
                    dataRegNext = {dataReg[6:0], 1'b0};
                end
                TX2: begin nextState = TX3; sclOutNext = 1'b1; end
                TX3: nextState = TX4;           // second high phase
                TX4: begin
                    sclOutNext     = 1'b0;
                    bitCounterNext = bitCounter + 3'd1;
                    nextState      = bitsDone ? TXACK1 : TX1;
                end

                TXACK1: begin nextState = TXACK2; sdaOutNext = 1'b1; end // release for ack
                TXACK2: begin nextState = TXACK3; sclOutNext = 1'b1; end
                TXACK3: begin nextState = TXACK4; ackRegNext = sdaIn; end // mid-high sample
                TXACK4: begin
                    nextState  = IDLE;
                    sclOutNext = 1'b0;
                    ackDone    = 1'b1;
                end

                RX1: nextState = RX2;           // slave sets up its bit
                RX2: begin nextState = RX3; sclOutNext = 1'b1; end
                RX3: begin
                    nextState   = RX4;
                    dataRegNext = {dataReg[6:0], sdaIn}; // msb first
                end
                RX4: begin
                    sclOutNext     = 1'b0;
                    bitCounterNext = bitCounter + 3'd1;
                    nextState      = bitsDone ? RXACK1 : RX1;
                end

                RXACK1: begin nextState = RXACK2; sdaOutNext = ackReg; end
                RXACK2: begin nextState = RXACK3; sclOutNext = 1'b1; end
                RXACK3: nextState = RXACK4;
                RXACK4: begin
                    nextState  = IDLE;
                    sclOutNext = 1'b0;
                    readDone   = 1'b1;
                end

                default: nextState = IDLE;
            endcase
        end
    end

    // room checked at take time must still be there when the byte lands
    assert property (@(posedge clk) disable iff (reset) readDone |-> readRoom)
        else $error("received byte with read queue full");
    // nobody else holds scl low once released
    assert property (@(posedge clk) disable iff (reset) (sclOut && $past(sclOut)) |-> sclIn)
        else $error("scl held low by another device");
    // data only moves under a high clock for start and stop conditions
    assert property (@(posedge clk) disable iff (reset)
        (sclOut && $past(sclOut) && sclIn && !(state inside {START4, STOP4}))
            |-> $stable(sdaOut))
        else $error("sda changed while scl high");

endmodule

`default_nettype wire

// ==== src/i2cQueue.sv ====
// small synchronous FIFO, payload type set by parameter
// circular buffer with read/write pointers and an entry count
// head entry shown on popData while notEmpty
`timescale 1ns/100ps
`default_nettype none

module i2cQueue #(
    parameter type payloadType = logic [7:0]
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        push,
    input  wire payloadType pushData,
    input  wire        pop,
    output payloadType popData,
    output logic       notEmpty,
    output logic       notFull
);
    import i2cHostPkg::*;

    localparam int ptrWidth   = $clog2(queueDepth);
    localparam int countWidth = $clog2(queueDepth + 1);

    payloadType            mem [queueDepth];
    logic [ptrWidth-1:0]   readPtr;
    logic [ptrWidth-1:0]   writePtr;
    logic [countWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (push) mem[writePtr] <= pushData; // storage, no reset
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readPtr  <= '0;
            writePtr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                writePtr <= (writePtr == ptrWidth'(queueDepth - 1)) ? '0 : writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= (readPtr == ptrWidth'(queueDepth - 1)) ? '0 : readPtr + 1'b1;
            end
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    assign popData  = mem[readPtr];
    assign notEmpty = (count != '0);
    assign notFull  = (count != countWidth'(queueDepth));

    // producer and consumer must honour the flags
    assert property (@(posedge clk) disable iff (reset) push |-> notFull)
        else $error("queue push while full");
    assert property (@(posedge clk) disable iff (reset) pop |-> notEmpty)
        else $error("queue pop while empty");

endmodule

`default_nettype wire

// ==== src/i2cClockDivider.sv ====
// phase timer for the bit engine
// down-counter, pulses cycleDone once every clocksPerCycle+1 clocks
`timescale 1ns/100ps
`default_nettype none

module i2cClockDivider (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] clocksPerCycle,  // phase length minus one
    input  wire        restart,         // config written, start a fresh phase
    output logic       cycleDone
);

    logic [7:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= 8'd0;
        end else if (restart || cycleDone) begin
            count <= clocksPerCycle;    // reload, new value applies right away
        end else begin
            count <= count - 8'd1;
        end
    end

    assign cycleDone = (count == 8'd0);

endmodule

`default_nettype wire

// ==== src/i2cHostPkg.sv ====
// host-side definitions for the i2c master
// register map, status bit layout, queue depth and divider reset value
`default_nettype none

package i2cHostPkg;

    // register addresses
    localparam logic [1:0] regData    = 2'd0;   // write pushes tx byte, read pops rx byte
    localparam logic [1:0] regCommand = 2'd1;   // bits 1:0 command, bit 2 receive ack
    localparam logic [1:0] regConfig  = 2'd2;   // clocksPerCycle
    localparam logic [1:0] regStatus  = 2'd3;

    // status register bits
    localparam int statusBusy      = 0;
    localparam int statusNack      = 1;         // sticky, write 1 to clear
    localparam int statusCmdFull   = 2;
    localparam int statusReadAvail = 3;

    localparam int queueDepth = 4;              // entries in each queue

    localparam logic [7:0] dividerReset = 8'd4; // phase = 5 clocks out of reset

endpackage

`default_nettype wire

// ==== src/i2cBusPkg.sv ====
// bus-side definitions for the i2c master
// command codes, command and read queue entries, engine phase states
`default_nettype none

package i2cBusPkg;

    typedef enum logic [1:0] {
        START    = 2'd0,
        STOP     = 2'd1,
        TRANSMIT = 2'd2,
        RECEIVE  = 2'd3
    } i2cCommand;

    typedef struct packed {
        i2cCommand  command;    // what the engine does
        logic [7:0] data;       // byte to send, unused for start/stop/receive
        logic       ack;        // level driven in the ack slot after a receive
    } i2cCommandEntry;

    typedef struct packed {
        logic [7:0] data;       // byte taken off the bus
    } i2cReadEntry;

    // four phases per sequence, entered on cycleDone
    typedef enum logic [4:0] {
        IDLE,
        START1, START2, START3, START4,
        STOP1,  STOP2,  STOP3,  STOP4,
        TX1,    TX2,    TX3,    TX4,
        TXACK1, TXACK2, TXACK3, TXACK4,
        RX1,    RX2,    RX3,    RX4,
        RXACK1, RXACK2, RXACK3, RXACK4
    } engineState;

endpackage

`default_nettype wire
